/* source/csr_defs.svh */
// CSR data and address widths, counter and fcsr addresses, fcsr field widths and masks
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// Datapath and address widths
`define CSR_XLEN        32
`define CSR_ADDR_W      12

// User counters, low and high halves
`define CSR_CYCLE       12'hC00
`define CSR_CYCLEH      12'hC80
`define CSR_INSTRET     12'hC02
`define CSR_INSTRETH    12'hC82

// Floating point status views
`define CSR_FFLAGS      12'h001
`define CSR_FRM         12'h002
`define CSR_FCSR        12'h003

// Field widths, frm sits right above fflags
`define CSR_FFLAGS_W    5
`define CSR_FRM_W       3

// Right-aligned field masks
`define CSR_FFLAGS_MASK 32'h0000001F
`define CSR_FRM_MASK    32'h00000007
`define CSR_FCSR_MASK   32'h000000FF

`endif

/* source/csrPkg.sv */
// Zicsr operation and FSM state enums, request and response structs
`include "csr_defs.svh"

package csrPkg;

        // Zicsr forms, same encoding as funct3
        typedef enum logic [2:0] {
                OP_RW  = 3'b001,
                OP_RS  = 3'b010,
                OP_RC  = 3'b011,
                OP_RWI = 3'b101,
                OP_RSI = 3'b110,
                OP_RCI = 3'b111
        } csrOp_e;

        // Handshake sequencer states
        typedef enum logic [1:0] {
                ST_IDLE = 2'd0,
                ST_EXEC = 2'd1,
                ST_ACK  = 2'd2
        } csrState_e;

        // One CSR instruction from the pipeline
        typedef struct packed {
                csrOp_e                 op;
                logic [`CSR_ADDR_W-1:0] addr;
                // Register operand for RW/RS/RC
                logic [`CSR_XLEN-1:0]   rs1Data;
                // Immediate, doubles as rs1 index
                logic [4:0]             uimm;
                // rs1 or uimm field is zero
                logic                   rs1IsZero;
        } csrReq_t;

        // Result back to the pipeline
        typedef struct packed {
                // Old register value
                logic [`CSR_XLEN-1:0]   rdData;
                logic                   illegal;
        } csrResp_t;

endpackage

/* source/csrRegFile.sv */
// CSR storage with counters, fcsr fields, read mux, masked writes and FPU flag accumulation
`timescale 1ns/1ps
`include "csr_defs.svh"

module csrRegFile (
        input  logic                   clk_i,
        input  logic                   reset_i,
        // Read port
        input  logic [`CSR_ADDR_W-1:0] rAddr_i,
        output logic [`CSR_XLEN-1:0]   rData_o,
        output logic                   rValid_o,
        // Write port
        input  logic                   wEn_i,
        input  logic [`CSR_ADDR_W-1:0] wAddr_i,
        input  logic [`CSR_XLEN-1:0]   wData_i,
        // Instret step
        input  logic                   retire_i,
        // FPU side
        input  logic                   fpuFlagsValid_i,
        input  logic [`CSR_FFLAGS_W-1:0] fpuFlags_i,
        output logic [`CSR_FRM_W-1:0]  frm_o
);

// Counters
logic [63:0] cycle;
logic [63:0] instret;

// fcsr fields kept apart
logic [`CSR_FFLAGS_W-1:0] fflags;
logic [`CSR_FRM_W-1:0]    frm;

// Whole fcsr as seen on the bus
logic [`CSR_XLEN-1:0] fcsrWord;
// fcsr after a CSR write, before flag merge
logic [`CSR_XLEN-1:0] fcsrNew;
// Incoming FPU flags, zero when not valid
logic [`CSR_FFLAGS_W-1:0] flagsIn;

assign fcsrWord = {{(`CSR_XLEN - `CSR_FRM_W - `CSR_FFLAGS_W){1'b0}}, frm, fflags};

// Read mux, every view right-aligned
always_comb begin
        rData_o  = '0;
        rValid_o = 1'b1;
        case (rAddr_i)
                `CSR_CYCLE:    rData_o = cycle[31:0];
                `CSR_CYCLEH:   rData_o = cycle[63:32];
                `CSR_INSTRET:  rData_o = instret[31:0];
                `CSR_INSTRETH: rData_o = instret[63:32];
                `CSR_FFLAGS:   rData_o = fcsrWord & `CSR_FFLAGS_MASK;
                `CSR_FRM:      rData_o = (fcsrWord >> `CSR_FFLAGS_W) & `CSR_FRM_MASK;
                `CSR_FCSR:     rData_o = fcsrWord & `CSR_FCSR_MASK;
                default: begin
                        // Unknown address reads zero
                        rValid_o = 1'b0;
                end
        endcase
end

// Field update for the three fcsr views
always_comb begin
        fcsrNew = fcsrWord;
        if (wEn_i) begin
                case (wAddr_i)
                        `CSR_FFLAGS: begin
                                fcsrNew = (fcsrWord & ~`CSR_FFLAGS_MASK)
                                        | (wData_i & `CSR_FFLAGS_MASK);
                        end
                        `CSR_FRM: begin
                                // Shift the view up above the flags
                                fcsrNew = (fcsrWord & ~(`CSR_FRM_MASK << `CSR_FFLAGS_W))
                                        | ((wData_i & `CSR_FRM_MASK) << `CSR_FFLAGS_W);
                        end
                        `CSR_FCSR: begin
                                fcsrNew = wData_i & `CSR_FCSR_MASK;
                        end
                        default: begin
                                fcsrNew = fcsrWord;
                        end
                endcase
        end
end

// FPU flags are sticky
assign flagsIn = fpuFlagsValid_i ? fpuFlags_i : '0;

// Counter update
always_ff @(posedge clk_i) begin
        if (reset_i) begin
                cycle   <= '0;
                instret <= '0;
        end else begin
                cycle <= cycle + 64'd1;
                if (retire_i) begin
                        instret <= instret + 64'd1;
                end
        end
end

// fcsr update, written value first then flags ORed on top
always_ff @(posedge clk_i) begin
        if (reset_i) begin
                fflags <= '0;
                frm    <= '0;
        end else begin
                fflags <= fcsrNew[`CSR_FFLAGS_W-1:0] | flagsIn;
                frm    <= fcsrNew[`CSR_FFLAGS_W +: `CSR_FRM_W];
        end
end

// Rounding mode to FPU
assign frm_o = frm;

endmodule

/* source/csrAlu.sv */
// Zicsr read-modify-write operator with write decision and illegal access detection
`timescale 1ns/1ps
`include "csr_defs.svh"

module csrAlu (
        input  csrPkg::csrReq_t      req_i,
        input  logic [`CSR_XLEN-1:0] oldData_i,
        input  logic                 addrValid_i,
        output logic [`CSR_XLEN-1:0] newData_o,
        output logic                 wEn_o,
        output logic                 illegal_o
);

// Source operand after form select
logic [`CSR_XLEN-1:0] operand;
// Write wanted by the instruction itself
logic                 wantWrite;
// Top two address bits 11 mean read-only
logic                 readOnly;

// Immediate forms take zero-extended uimm
always_comb begin
        if (req_i.op inside {csrPkg::OP_RWI, csrPkg::OP_RSI, csrPkg::OP_RCI}) begin
                operand = {{(`CSR_XLEN - $bits(req_i.uimm)){1'b0}}, req_i.uimm};
        end else begin
                operand = req_i.rs1Data;
        end
end

// New value and Zicsr write rule
always_comb begin
        newData_o = oldData_i;
        wantWrite = 1'b0;
        case (req_i.op)
                csrPkg::OP_RW, csrPkg::OP_RWI: begin
                        newData_o = operand;
                        wantWrite = 1'b1;
                end
                csrPkg::OP_RS, csrPkg::OP_RSI: begin
                        newData_o = oldData_i | operand;
                        wantWrite = !req_i.rs1IsZero;
                end
                csrPkg::OP_RC, csrPkg::OP_RCI: begin
                        newData_o = oldData_i & ~operand;
                        wantWrite = !req_i.rs1IsZero;
                end
                default: begin
                        // Reserved funct3, no side effect
                        wantWrite = 1'b0;
                end
        endcase
end

assign readOnly  = &req_i.addr[`CSR_ADDR_W-1 -: 2];
assign illegal_o = !addrValid_i || (wantWrite && readOnly);
// Illegal access changes nothing
assign wEn_o     = wantWrite && !illegal_o;

endmodule

/* source/csrUnit.sv */
// Zicsr unit top with four-phase req/ack FSM, register file and read-modify-write operator
`timescale 1ns/1ps
`include "csr_defs.svh"

module csrUnit (
        input  logic                     clk_i,
        input  logic                     reset_i,
        // Pipeline handshake
        input  logic                     req_i,
        input  csrPkg::csrReq_t          reqData_i,
        output logic                     ack_o,
        output csrPkg::csrResp_t         resp_o,
        // Instret step
        input  logic                     retire_i,
        // FPU side
        input  logic                     fpuFlagsValid_i,
        input  logic [`CSR_FFLAGS_W-1:0] fpuFlags_i,
        output logic [`CSR_FRM_W-1:0]    frm_o
);

// Sequencer state
csrPkg::csrState_e state;

// Request captured on the accepting edge
csrPkg::csrReq_t reqReg;

// Register file read side
logic [`CSR_XLEN-1:0] rData;
logic                 rValid;

// Operator results
logic [`CSR_XLEN-1:0] newData;
logic                 aluWEn;
logic                 illegal;

// Write strobe only during the execute cycle
logic                 wEn;

assign wEn = (state == csrPkg::ST_EXEC) && aluWEn;

csrRegFile regFile_i (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .rAddr_i         (reqReg.addr),
        .rData_o         (rData),
        .rValid_o        (rValid),
        .wEn_i           (wEn),
        .wAddr_i         (reqReg.addr),
        .wData_i         (newData),
        .retire_i        (retire_i),
        .fpuFlagsValid_i (fpuFlagsValid_i),
        .fpuFlags_i      (fpuFlags_i),
        .frm_o           (frm_o)
);

csrAlu alu_i (
        .req_i       (reqReg),
        .oldData_i   (rData),
        .addrValid_i (rValid),
        .newData_o   (newData),
        .wEn_o       (aluWEn),
        .illegal_o   (illegal)
);

// Handshake FSM
always_ff @(posedge clk_i) begin
        if (reset_i) begin
                state <= csrPkg::ST_IDLE;
                ack_o <= 1'b0;
        end else begin
                case (state)
                        csrPkg::ST_IDLE: begin
                                // Accept a new request
                                if (req_i) begin
                                        state <= csrPkg::ST_EXEC;
                                end
                        end
                        csrPkg::ST_EXEC: begin
                                // Write lands here, ack goes up
                                ack_o <= 1'b1;
                                state <= csrPkg::ST_ACK;
                        end
                        csrPkg::ST_ACK: begin
                                // Hold until the pipeline lets go
                                if (!req_i) begin
                                        ack_o <= 1'b0;
                                        state <= csrPkg::ST_IDLE;
                                end
                        end
                        default: begin
                                ack_o <= 1'b0;
                                state <= csrPkg::ST_IDLE;
                        end
                endcase
        end
end

// Request register, loaded on accept only
always_ff @(posedge clk_i) begin
        if ((state == csrPkg::ST_IDLE) && req_i) begin
                reqReg <= reqData_i;
        end
end

// Response register
always_ff @(posedge clk_i) begin
        if (state == csrPkg::ST_EXEC) begin
                // Old value returned even when illegal
                resp_o.rdData  <= rData;
                resp_o.illegal <= illegal;
        end
end

endmodule

/* dv/csrUnitChecker.sv */
// Bound handshake checker with reset, ack timing and response stability assertions
`timescale 1ns/1ps

module csrUnitChecker (
        input logic              clk_i,
        input logic              reset_i,
        input logic              req_i,
        input logic              ack_i,
        input csrPkg::csrResp_t  resp_i,
        input csrPkg::csrState_e state_i
);

// Failure tallies, one per assertion, read by the testbench
int unsigned failReset  = 0;
int unsigned failRise   = 0;
int unsigned failStable = 0;
int unsigned failFall   = 0;

// No ack in the first cycle after reset
ackLowAfterReset: assert property (@(posedge clk_i) reset_i |=> !ack_i)
        else begin
                failReset++;
                $error("ack_o is high in the cycle after reset");
        end

// Accept edge, then execute edge, then ack seen high
ackRiseTwoEdges: assert property (@(posedge clk_i) disable iff (reset_i)
        (state_i == csrPkg::ST_IDLE && req_i) |=> !ack_i ##1 ack_i)
        else begin
                failRise++;
                $error("ack_o did not rise two edges after the request was accepted");
        end

// Response frozen while ack is held
respStableOnAck: assert property (@(posedge clk_i) disable iff (reset_i)
        ack_i |=> (!ack_i || $stable(resp_i)))
        else begin
                failStable++;
                $error("resp_o changed while ack_o was high");
        end

// Release of req drops ack on the next edge
ackFallAfterRelease: assert property (@(posedge clk_i) disable iff (reset_i)
        (ack_i && !req_i) |=> !ack_i)
        else begin
                failFall++;
                $error("ack_o stayed high after req_i was sampled low");
        end

endmodule

bind csrUnit csrUnitChecker checker_i (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .req_i   (req_i),
        .ack_i   (ack_o),
        .resp_i  (resp_o),
        .state_i (state)
);

/* dv/csrUnitTb.sv */
// CSR unit testbench with handshake driver, fcsr reference model and per-test report
`timescale 1ns/1ps
`include "csr_defs.svh"

module csrUnitTb;

// Cycles allowed for any single ack transition
localparam int TIMEOUT = 50;

logic                     clk;
logic                     reset;
logic                     req;
csrPkg::csrReq_t          reqData;
logic                     ack;
csrPkg::csrResp_t         resp;
logic                     retire;
logic                     fpuFlagsValid;
logic [`CSR_FFLAGS_W-1:0] fpuFlags;
logic [`CSR_FRM_W-1:0]    frm;

// Reference fcsr fields
logic [`CSR_FFLAGS_W-1:0] modelFflags;
logic [`CSR_FRM_W-1:0]    modelFrm;

int errors;
int checks;
int testErrors;
int testCount;

// Funct3 order with set and clear forms at 1, 2, 4 and 5
csrPkg::csrOp_e opList [6] = '{csrPkg::OP_RW, csrPkg::OP_RS, csrPkg::OP_RC,
                               csrPkg::OP_RWI, csrPkg::OP_RSI, csrPkg::OP_RCI};
// Known addresses plus one unmapped
logic [11:0] addrList [8] = '{`CSR_CYCLE, `CSR_CYCLEH, `CSR_INSTRET, `CSR_INSTRETH,
                              `CSR_FFLAGS, `CSR_FRM, `CSR_FCSR, 12'h7C0};
logic [11:0] fpViews [3] = '{`CSR_FFLAGS, `CSR_FRM, `CSR_FCSR};

csrUnit dut_i (
        .clk_i           (clk),
        .reset_i         (reset),
        .req_i           (req),
        .reqData_i       (reqData),
        .ack_o           (ack),
        .resp_o          (resp),
        .retire_i        (retire),
        .fpuFlagsValid_i (fpuFlagsValid),
        .fpuFlags_i      (fpuFlags),
        .frm_o           (frm)
);

always #50 clk = ~clk;

// Rising edge plus drive offset
task automatic nextCycle();
        @(posedge clk);
        #1;
endtask

task automatic idleCycles(input int n);
        repeat (n) nextCycle();
endtask

task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
                $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
                errors++;
                testErrors++;
        end
endtask

task automatic checkAtLeast(input string name, input logic [31:0] got, input logic [31:0] minVal);
        checks++;
        assert (got >= minVal) else begin
                $display("error %s: got 0x%h, expected at least 0x%h", name, got, minVal);
                errors++;
                testErrors++;
        end
endtask

task automatic abortRun(input string what);
        $display("%s", what);
        $display("Test failed");
        $finish;
endtask

// One full four-phase transfer with req held for hold extra cycles after ack
task automatic runRequest(input csrPkg::csrOp_e op, input logic [11:0] addr,
                input logic [31:0] rs1, input logic [4:0] uimm, input int hold,
                output logic [31:0] rdData, output logic illegal);
        int waitCnt;
        reqData.op        = op;
        reqData.addr      = addr;
        reqData.rs1Data   = rs1;
        reqData.uimm      = uimm;
        reqData.rs1IsZero = (uimm == 5'd0);
        req = 1'b1;
        waitCnt = 0;
        while (!ack && waitCnt < TIMEOUT) begin
                nextCycle();
                waitCnt++;
        end
        if (!ack) begin
                abortRun("timeout: ack_o never rose for the pending request");
        end else begin
                rdData  = resp.rdData;
                illegal = resp.illegal;
                idleCycles(hold);
                req = 1'b0;
                waitCnt = 0;
                while (ack && waitCnt < TIMEOUT) begin
                        nextCycle();
                        waitCnt++;
                end
                if (ack) begin
                        abortRun("timeout: ack_o never fell after req_i was released");
                end
        end
endtask

// Plain read as a set form with zero immediate
task automatic readCsr(input logic [11:0] addr, output logic [31:0] data, output logic ill);
        runRequest(csrPkg::OP_RSI, addr, 32'h0, 5'd0, 0, data, ill);
endtask

// Immediate forms have funct3 bit 2 set
function automatic logic [31:0] operandOf(csrPkg::csrOp_e op, logic [31:0] rs1, logic [4:0] uimm);
        return op[2] ? {27'd0, uimm} : rs1;
endfunction

function automatic logic [31:0] rmwValue(csrPkg::csrOp_e op, logic [31:0] old, logic [31:0] src);
        case (op)
                csrPkg::OP_RW, csrPkg::OP_RWI: return src;
                csrPkg::OP_RS, csrPkg::OP_RSI: return old | src;
                default: return old & ~src;
        endcase
endfunction

// Swap forms always write while set and clear need a nonzero source field
function automatic bit writesReg(csrPkg::csrOp_e op, logic [4:0] uimm);
        return (op == csrPkg::OP_RW) || (op == csrPkg::OP_RWI) || (uimm != 5'd0);
endfunction

function automatic logic [31:0] modelView(logic [11:0] addr);
        case (addr)
                `CSR_FFLAGS: return {27'd0, modelFflags};
                `CSR_FRM:    return {29'd0, modelFrm};
                default:     return {24'd0, modelFrm, modelFflags};
        endcase
endfunction

task automatic updateModel(input logic [11:0] addr, input logic [31:0] val);
        case (addr)
                `CSR_FFLAGS: modelFflags = val[4:0];
                `CSR_FRM:    modelFrm = val[2:0];
                default:     {modelFrm, modelFflags} = val[7:0];
        endcase
endtask

// One RMW on an fcsr view that checks the old value and advances the model
task automatic rmwStep(input csrPkg::csrOp_e op, input logic [11:0] addr,
                input logic [31:0] rs1, input logic [4:0] uimm);
        logic [31:0] old;
        logic [31:0] rd;
        logic        ill;
        old = modelView(addr);
        runRequest(op, addr, rs1, uimm, 0, rd, ill);
        checkValue("resp_o.rdData", rd, old);
        checkValue("resp_o.illegal", {31'd0, ill}, 32'd0);
        if (writesReg(op, uimm)) begin
                updateModel(addr, rmwValue(op, old, operandOf(op, rs1, uimm)));
        end
endtask

task automatic reportTest(input string name);
        $display("%s: done with %0d errors", name, testErrors);
        testCount++;
        testErrors = 0;
endtask

initial begin
        logic [31:0] rd;
        logic [31:0] c1;
        logic [31:0] c2;
        logic        ill;
        logic [11:0] addr;
        int          n;
        void'($urandom(64));
        clk = 1'b0;
        reset = 1'b1;
        req = 1'b0;
        reqData = '0;
        retire = 1'b0;
        fpuFlagsValid = 1'b0;
        fpuFlags = '0;
        modelFflags = '0;
        modelFrm = '0;
        errors = 0;
        checks = 0;
        testErrors = 0;
        testCount = 0;
        idleCycles(16);
        reset = 1'b0;
        nextCycle();

        // Random reads over the whole map with back-pressure
        for (int i = 0; i < 20; i++) begin
                addr = addrList[$urandom_range(0, 7)];
                n = $urandom_range(1, 2) + 3 * $urandom_range(0, 1);
                runRequest(opList[n], addr, 32'h0, 5'd0, $urandom_range(0, 3), rd, ill);
                if (addr == `CSR_FFLAGS || addr == `CSR_FRM || addr == `CSR_FCSR) begin
                        checkValue("resp_o.rdData", rd, modelView(addr));
                end
                idleCycles($urandom_range(0, 2));
        end
        reportTest("handshake");

        // Random RMW on the fcsr views with read-back
        for (int i = 0; i < 30; i++) begin
                addr = fpViews[$urandom_range(0, 2)];
                rmwStep(opList[$urandom_range(0, 5)], addr, $urandom, 5'($urandom));
                readCsr(addr, rd, ill);
                checkValue("resp_o.rdData", rd, modelView(addr));
                checkValue("frm_o", {29'd0, frm}, {29'd0, modelFrm});
        end
        reportTest("read-modify-write");

        // Zero source field with live rs1 data leaves the register alone
        rmwStep(csrPkg::OP_RW, `CSR_FCSR, $urandom, 5'd7);
        for (int v = 0; v < 3; v++) begin
                foreach (opList[k]) begin
                        if (k == 1 || k == 2) begin
                                c1 = modelView(fpViews[v]);
                                rmwStep(opList[k], fpViews[v], $urandom, 5'd0);
                                readCsr(fpViews[v], rd, ill);
                                checkValue("resp_o.rdData", rd, c1);
                        end
                end
        end
        reportTest("zero operand");

        // Counters with instret untouched until now
        readCsr(`CSR_INSTRET, rd, ill);
        checkValue("instret", rd, 32'd0);
        readCsr(`CSR_CYCLE, c1, ill);
        n = $urandom_range(5, 20);
        idleCycles(n);
        readCsr(`CSR_CYCLE, c2, ill);
        checkAtLeast("cycle delta", c2 - c1, n);
        n = $urandom_range(3, 12);
        for (int i = 0; i < n; i++) begin
                retire = 1'b1;
                nextCycle();
                retire = 1'b0;
                idleCycles($urandom_range(0, 2));
        end
        readCsr(`CSR_INSTRET, rd, ill);
        checkValue("instret", rd, n);
        readCsr(`CSR_CYCLEH, rd, ill);
        checkValue("cycleh", rd, 32'd0);
        readCsr(`CSR_INSTRETH, rd, ill);
        checkValue("instreth", rd, 32'd0);
        reportTest("counters");

        // Write to a counter and an unmapped address
        readCsr(`CSR_CYCLE, c1, ill);
        runRequest(csrPkg::OP_RW, `CSR_CYCLE, 32'h0, 5'd3, 0, rd, ill);
        checkValue("resp_o.illegal", {31'd0, ill}, 32'd1);
        checkAtLeast("resp_o.rdData", rd, c1 + 32'd1);
        readCsr(`CSR_CYCLE, c2, ill);
        checkAtLeast("cycle", c2, c1 + 32'd4);
        runRequest(csrPkg::OP_RSI, `CSR_INSTRET, 32'h0, 5'd5, 0, rd, ill);
        checkValue("resp_o.illegal", {31'd0, ill}, 32'd1);
        runRequest(csrPkg::OP_RW, 12'h7C0, $urandom, 5'd9, 0, rd, ill);
        checkValue("resp_o.illegal", {31'd0, ill}, 32'd1);
        checkValue("resp_o.rdData", rd, 32'd0);
        reportTest("illegal access");

        // Sticky FPU flags after clearing fflags
        rmwStep(csrPkg::OP_RWI, `CSR_FFLAGS, 32'h0, 5'd0);
        for (int i = 0; i < 12; i++) begin
                fpuFlagsValid = 1'b1;
                fpuFlags = 5'($urandom);
                modelFflags = modelFflags | fpuFlags;
                nextCycle();
                fpuFlagsValid = 1'b0;
                idleCycles($urandom_range(0, 1));
        end
        readCsr(`CSR_FFLAGS, rd, ill);
        checkValue("fflags", rd, modelView(`CSR_FFLAGS));
        readCsr(`CSR_FCSR, rd, ill);
        checkValue("fcsr", rd, modelView(`CSR_FCSR));
        reportTest("fpu flags");

        // Bound assertion failures count too
        errors += int'(dut_i.checker_i.failReset + dut_i.checker_i.failRise
                + dut_i.checker_i.failStable + dut_i.checker_i.failFall);
        $display("tests %0d, checks %0d, errors %0d", testCount, checks, errors);
        if (errors == 0) begin
                $display("Test passed");
        end else begin
                $display("Test failed");
        end
        $finish;
end

endmodule

/* csrUnit.f */
+incdir+source
source/csrPkg.sv
source/csrRegFile.sv
source/csrAlu.sv
source/csrUnit.sv
dv/csrUnitChecker.sv
dv/csrUnitTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# Build and run the CSR unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module csrUnitTb -f csrUnit.f

# Keep running past assertion errors so the testbench can report them
./obj_dir/VcsrUnitTb +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
        echo "Simulation failed, see sim.log"
        exit 1
fi
if ! grep -q "Test passed" sim.log; then
        echo "Simulation ended without a result, see sim.log"
        exit 1
fi
echo "Simulation finished cleanly"
